// ==== rtl/jtag_pkg.sv ====
`default_nettype none

package jtag_pkg;

	// Instruction register
	localparam int IR_W = 4;
	localparam logic [IR_W-1:0] INSTR_IDCODE = 4'h1;
	localparam logic [IR_W-1:0] INSTR_REG_ACCESS = 4'h8;
	localparam logic [IR_W-1:0] INSTR_BYPASS = 4'hF;

	// Register bus and access scan layout {write, addr, data}
	localparam int ADDR_W = 4;
	localparam int DATA_W = 16;
	localparam int ACCESS_DR_W = 1 + ADDR_W + DATA_W;

	localparam int N_CFG = 4;
	localparam int N_STAT = 3;

	localparam logic [ADDR_W-1:0] ADDR_CDR_CTRL = 4'd0;
	localparam logic [ADDR_W-1:0] ADDR_PRBS_CTRL = 4'd1;
	localparam logic [ADDR_W-1:0] ADDR_SRAM_ADDR = 4'd2;
	localparam logic [ADDR_W-1:0] ADDR_RST_CTRL = 4'd3;

	localparam logic [ADDR_W-1:0] ADDR_PHASE_EST = 4'd8;
	localparam logic [ADDR_W-1:0] ADDR_PRBS_ERR = 4'd9;
	localparam logic [ADDR_W-1:0] ADDR_SRAM_DATA = 4'd10;

	// Control field widths
	localparam int KI_W = 4;
	localparam int KP_W = 4;
	localparam int PI_CTL_W = 6;
	localparam int PRBS_MODE_W = 2;
	localparam int SRAM_ADDR_W = 10;

	// RST_CTRL release bits
	localparam int RST_CDR_BIT = 0;
	localparam int RST_PRBS_BIT = 1;
	localparam int RST_SRAM_BIT = 2;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic en_ext_pi_ctl;
			logic invert;
			logic [KI_W-1:0] ki;
			logic [KP_W-1:0] kp;
			logic [PI_CTL_W-1:0] ext_pi_ctl;
		} f;
	} cdr_ctrl_u;

endpackage

`default_nettype wire

// ==== rtl/dbg_bus_if.sv ====
`default_nettype none

interface dbg_bus_if;
	logic req;
	logic ack;
	logic write;
	logic [jtag_pkg::ADDR_W-1:0] addr;
	logic [jtag_pkg::DATA_W-1:0] wdata;
	logic [jtag_pkg::DATA_W-1:0] rdata;

	modport requester (
		output req,
		output write,
		output addr,
		output wdata,
		input ack,
		input rdata
	);

	modport responder (
		input req,
		input write,
		input addr,
		input wdata,
		output ack,
		output rdata
	);
endinterface

`default_nettype wire

// ==== rtl/tck_sync.sv ====
`default_nettype none

module tck_sync #(
	parameter int SYNC_STAGES = 2
) (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tms_o,
	output logic tdi_o,
	output logic trst_n_o
);
	// Bit order {trst_n, tdi, tms, tck}
	logic [SYNC_STAGES-1:0][3:0] sync_q;
	logic [3:0] pins_s;
	logic tck_q;

	assign pins_s = sync_q[SYNC_STAGES-1];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync_q <= '0;
			tck_q <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
			tms_o <= 1'b0;
			tdi_o <= 1'b0;
			trst_n_o <= 1'b0;
		end else begin
			sync_q[0] <= {trst_n_i, tdi_i, tms_i, tck_i};
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			tck_q <= pins_s[0];
			tck_rise_o <= pins_s[0] & ~tck_q;
			tck_fall_o <= ~pins_s[0] & tck_q;
			// Same extra stage as the edge pulses
			tms_o <= pins_s[1];
			tdi_o <= pins_s[2];
			trst_n_o <= pins_s[3];
		end
	end
endmodule

`default_nettype wire

// ==== rtl/jtag_tap.sv ====
`default_nettype none

module jtag_tap #(
	parameter logic [31:0] IDCODE = 32'h0000_0001
) (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic tck_rise_i,
	input wire logic tck_fall_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,
	dbg_bus_if.requester bus_o
);
	localparam logic [3:0] S_TLR = 4'd0;
	localparam logic [3:0] S_RTI = 4'd1;
	localparam logic [3:0] S_SEL_DR = 4'd2;
	localparam logic [3:0] S_CAP_DR = 4'd3;
	localparam logic [3:0] S_SHIFT_DR = 4'd4;
	localparam logic [3:0] S_EXIT1_DR = 4'd5;
	localparam logic [3:0] S_PAUSE_DR = 4'd6;
	localparam logic [3:0] S_EXIT2_DR = 4'd7;
	localparam logic [3:0] S_UPD_DR = 4'd8;
	localparam logic [3:0] S_SEL_IR = 4'd9;
	localparam logic [3:0] S_CAP_IR = 4'd10;
	localparam logic [3:0] S_SHIFT_IR = 4'd11;
	localparam logic [3:0] S_EXIT1_IR = 4'd12;
	localparam logic [3:0] S_PAUSE_IR = 4'd13;
	localparam logic [3:0] S_EXIT2_IR = 4'd14;
	localparam logic [3:0] S_UPD_IR = 4'd15;

	logic [3:0] state;
	logic [3:0] state_nxt;
	logic [jtag_pkg::IR_W-1:0] ir;
	logic [jtag_pkg::IR_W-1:0] ir_sr;
	logic [31:0] idcode_sr;
	logic [jtag_pkg::ACCESS_DR_W-1:0] access_sr;
	logic bypass_sr;
	logic dr_bit;
	logic update_stb;
	logic req_q;
	logic write_q;
	logic [jtag_pkg::ADDR_W-1:0] addr_q;
	logic [jtag_pkg::DATA_W-1:0] wdata_q;

	always_comb begin
		state_nxt = state;
		case (state)
			S_TLR: state_nxt = tms_i ? S_TLR : S_RTI;
			S_RTI: state_nxt = tms_i ? S_SEL_DR : S_RTI;
			S_SEL_DR: state_nxt = tms_i ? S_SEL_IR : S_CAP_DR;
			S_CAP_DR: state_nxt = tms_i ? S_EXIT1_DR : S_SHIFT_DR;
			S_SHIFT_DR: state_nxt = tms_i ? S_EXIT1_DR : S_SHIFT_DR;
			S_EXIT1_DR: state_nxt = tms_i ? S_UPD_DR : S_PAUSE_DR;
			S_PAUSE_DR: state_nxt = tms_i ? S_EXIT2_DR : S_PAUSE_DR;
			S_EXIT2_DR: state_nxt = tms_i ? S_UPD_DR : S_SHIFT_DR;
			S_UPD_DR: state_nxt = tms_i ? S_SEL_DR : S_RTI;
			S_SEL_IR: state_nxt = tms_i ? S_TLR : S_CAP_IR;
			S_CAP_IR: state_nxt = tms_i ? S_EXIT1_IR : S_SHIFT_IR;
			S_SHIFT_IR: state_nxt = tms_i ? S_EXIT1_IR : S_SHIFT_IR;
			S_EXIT1_IR: state_nxt = tms_i ? S_UPD_IR : S_PAUSE_IR;
			S_PAUSE_IR: state_nxt = tms_i ? S_EXIT2_IR : S_PAUSE_IR;
			S_EXIT2_IR: state_nxt = tms_i ? S_UPD_IR : S_SHIFT_IR;
			S_UPD_IR: state_nxt = tms_i ? S_SEL_DR : S_RTI;
		endcase
	end

	// Unknown opcodes fall back to bypass
	always_comb begin
		case (ir)
			jtag_pkg::INSTR_IDCODE: dr_bit = idcode_sr[0];
			jtag_pkg::INSTR_REG_ACCESS: dr_bit = access_sr[0];
			default: dr_bit = bypass_sr;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= S_TLR;
			ir <= jtag_pkg::INSTR_IDCODE;
			ir_sr <= '0;
			idcode_sr <= '0;
			access_sr <= '0;
			bypass_sr <= 1'b0;
			update_stb <= 1'b0;
		end else if (!trst_n_i) begin
			state <= S_TLR;
			ir <= jtag_pkg::INSTR_IDCODE;
			update_stb <= 1'b0;
		end else begin
			update_stb <= tck_rise_i && (state_nxt == S_UPD_DR);
			if (tck_rise_i) begin
				state <= state_nxt;
				case (state)
					S_CAP_IR: ir_sr <= jtag_pkg::IR_W'(1);
					S_SHIFT_IR: ir_sr <= {tdi_i, ir_sr[jtag_pkg::IR_W-1:1]};
					S_CAP_DR: begin
						idcode_sr <= IDCODE;
						access_sr <= {1'b0, addr_q, bus_o.rdata};
						bypass_sr <= 1'b0;
					end
					S_SHIFT_DR: begin
						case (ir)
							jtag_pkg::INSTR_IDCODE: idcode_sr <= {tdi_i, idcode_sr[31:1]};
							jtag_pkg::INSTR_REG_ACCESS: begin
								access_sr <= {tdi_i, access_sr[jtag_pkg::ACCESS_DR_W-1:1]};
							end
							default: bypass_sr <= tdi_i;
						endcase
					end
					default: ;
				endcase
				if (state_nxt == S_UPD_IR) begin
					ir <= ir_sr;
				end else if (state_nxt == S_TLR) begin
					ir <= jtag_pkg::INSTR_IDCODE;
				end
			end
		end
	end

	// Requester side of the four-phase bus
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_q <= 1'b0;
			write_q <= 1'b0;
			addr_q <= '0;
			wdata_q <= '0;
		end else if (req_q) begin
			if (bus_o.ack) begin
				req_q <= 1'b0;
			end
		end else if (update_stb && ir == jtag_pkg::INSTR_REG_ACCESS) begin
			req_q <= 1'b1;
			{write_q, addr_q, wdata_q} <= access_sr;
		end
	end

	assign bus_o.req = req_q;
	assign bus_o.write = write_q;
	assign bus_o.addr = addr_q;
	assign bus_o.wdata = wdata_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			if (state == S_SHIFT_IR) begin
				tdo_o <= ir_sr[0];
			end else if (state == S_SHIFT_DR) begin
				tdo_o <= dr_bit;
			end else begin
				tdo_o <= 1'b0;
			end
		end
	end

	// Previous access must be fully closed before the next update
	a_update_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
		(tck_rise_i && trst_n_i && state_nxt == S_UPD_DR) |-> !(bus_o.req || bus_o.ack));

	a_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
		$fell(bus_o.req) |-> $past(bus_o.ack));
endmodule

`default_nettype wire

// ==== rtl/dbg_regfile.sv ====
`default_nettype none

module dbg_regfile (
	input wire logic clk,
	input wire logic arst_n_i,
	dbg_bus_if.responder bus_i,
	output logic [jtag_pkg::N_CFG-1:0][jtag_pkg::DATA_W-1:0] cfg_o,
	input wire logic [jtag_pkg::N_STAT-1:0][jtag_pkg::DATA_W-1:0] stat_i
);
	localparam int CFG_IDX_W = $clog2(jtag_pkg::N_CFG);
	localparam int STAT_IDX_W = $clog2(jtag_pkg::N_STAT);

	logic ack_q;
	logic [jtag_pkg::DATA_W-1:0] rdata_q;
	logic [jtag_pkg::DATA_W-1:0] rd_word;
	logic cfg_hit;
	logic stat_hit;
	logic [CFG_IDX_W-1:0] cfg_idx;
	logic [STAT_IDX_W-1:0] stat_idx;

	// Config words sit at their own address, status words from 8 up
	assign cfg_hit = bus_i.addr < jtag_pkg::ADDR_W'(jtag_pkg::N_CFG);
	assign stat_hit = bus_i.addr inside {[jtag_pkg::ADDR_PHASE_EST:jtag_pkg::ADDR_SRAM_DATA]};
	assign cfg_idx = CFG_IDX_W'(bus_i.addr);
	assign stat_idx = STAT_IDX_W'(bus_i.addr - jtag_pkg::ADDR_PHASE_EST);

	always_comb begin
		rd_word = '0;
		if (cfg_hit) begin
			rd_word = cfg_o[cfg_idx];
		end else if (stat_hit) begin
			rd_word = stat_i[stat_idx];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
			rdata_q <= '0;
			cfg_o <= '0;
		end else if (bus_i.req && !ack_q) begin
			if (bus_i.write) begin
				// Status and unmapped writes are dropped
				if (cfg_hit) begin
					cfg_o[cfg_idx] <= bus_i.wdata;
				end
			end else begin
				rdata_q <= rd_word;
			end
			ack_q <= 1'b1;
		end else if (!bus_i.req) begin
			ack_q <= 1'b0;
		end
	end

	assign bus_i.ack = ack_q;
	assign bus_i.rdata = rdata_q;

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(bus_i.ack) |-> bus_i.req);
endmodule

`default_nettype wire

// ==== rtl/dbg_router.sv ====
`default_nettype none

module dbg_router (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic [jtag_pkg::N_CFG-1:0][jtag_pkg::DATA_W-1:0] cfg_i,
	output logic [jtag_pkg::N_STAT-1:0][jtag_pkg::DATA_W-1:0] stat_o,
	output logic cdr_en_ext_pi_ctl_o,
	output logic cdr_invert_o,
	output logic [jtag_pkg::KI_W-1:0] cdr_ki_o,
	output logic [jtag_pkg::KP_W-1:0] cdr_kp_o,
	output logic [jtag_pkg::PI_CTL_W-1:0] cdr_ext_pi_ctl_o,
	output logic [jtag_pkg::PRBS_MODE_W-1:0] prbs_checker_mode_o,
	output logic [jtag_pkg::SRAM_ADDR_W-1:0] sram_in_addr_o,
	output logic cdr_rst_n_o,
	output logic prbs_rst_n_o,
	output logic sram_rst_n_o,
	input wire logic [jtag_pkg::DATA_W-1:0] phase_est_i,
	input wire logic [jtag_pkg::DATA_W-1:0] prbs_err_cnt_i,
	input wire logic [jtag_pkg::DATA_W-1:0] sram_out_data_i
);
	jtag_pkg::cdr_ctrl_u cdr_w;
	logic [jtag_pkg::DATA_W-1:0] rst_w;

	// CDR
	assign cdr_w.raw = cfg_i[jtag_pkg::ADDR_CDR_CTRL];
	assign cdr_en_ext_pi_ctl_o = cdr_w.f.en_ext_pi_ctl;
	assign cdr_invert_o = cdr_w.f.invert;
	assign cdr_ki_o = cdr_w.f.ki;
	assign cdr_kp_o = cdr_w.f.kp;
	assign cdr_ext_pi_ctl_o = cdr_w.f.ext_pi_ctl;

	// PRBS and SRAM
	assign prbs_checker_mode_o = cfg_i[jtag_pkg::ADDR_PRBS_CTRL][jtag_pkg::PRBS_MODE_W-1:0];
	assign sram_in_addr_o = cfg_i[jtag_pkg::ADDR_SRAM_ADDR][jtag_pkg::SRAM_ADDR_W-1:0];

	// Blocks stay in reset while the chip is in reset
	assign rst_w = cfg_i[jtag_pkg::ADDR_RST_CTRL];
	assign cdr_rst_n_o = arst_n_i & rst_w[jtag_pkg::RST_CDR_BIT];
	assign prbs_rst_n_o = arst_n_i & rst_w[jtag_pkg::RST_PRBS_BIT];
	assign sram_rst_n_o = arst_n_i & rst_w[jtag_pkg::RST_SRAM_BIT];

	always_ff @(posedge clk) begin
		stat_o[jtag_pkg::ADDR_PHASE_EST - jtag_pkg::ADDR_PHASE_EST] <= phase_est_i;
		stat_o[jtag_pkg::ADDR_PRBS_ERR - jtag_pkg::ADDR_PHASE_EST] <= prbs_err_cnt_i;
		stat_o[jtag_pkg::ADDR_SRAM_DATA - jtag_pkg::ADDR_PHASE_EST] <= sram_out_data_i;
	end
endmodule

`default_nettype wire

// ==== rtl/jtag_top.sv ====
`default_nettype none

module jtag_top #(
	parameter logic [31:0] IDCODE = 32'h4a7d_1043,
	parameter int SYNC_STAGES = 2
) (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,
	output logic cdr_en_ext_pi_ctl_o,
	output logic cdr_invert_o,
	output logic [jtag_pkg::KI_W-1:0] cdr_ki_o,
	output logic [jtag_pkg::KP_W-1:0] cdr_kp_o,
	output logic [jtag_pkg::PI_CTL_W-1:0] cdr_ext_pi_ctl_o,
	output logic [jtag_pkg::PRBS_MODE_W-1:0] prbs_checker_mode_o,
	output logic [jtag_pkg::SRAM_ADDR_W-1:0] sram_in_addr_o,
	output logic cdr_rst_n_o,
	output logic prbs_rst_n_o,
	output logic sram_rst_n_o,
	input wire logic [jtag_pkg::DATA_W-1:0] phase_est_i,
	input wire logic [jtag_pkg::DATA_W-1:0] prbs_err_cnt_i,
	input wire logic [jtag_pkg::DATA_W-1:0] sram_out_data_i
);
	logic tck_rise;
	logic tck_fall;
	logic tms_s;
	logic tdi_s;
	logic trst_n_s;
	logic [jtag_pkg::N_CFG-1:0][jtag_pkg::DATA_W-1:0] cfg;
	logic [jtag_pkg::N_STAT-1:0][jtag_pkg::DATA_W-1:0] stat;

	dbg_bus_if dbg_bus_i ();

	tck_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) tck_sync_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tck_rise_o(tck_rise),
		.tck_fall_o(tck_fall),
		.tms_o(tms_s),
		.tdi_o(tdi_s),
		.trst_n_o(trst_n_s)
	);

	jtag_tap #(
		.IDCODE(IDCODE)
	) jtag_tap_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.tck_rise_i(tck_rise),
		.tck_fall_i(tck_fall),
		.tms_i(tms_s),
		.tdi_i(tdi_s),
		.trst_n_i(trst_n_s),
		.tdo_o(tdo_o),
		.bus_o(dbg_bus_i.requester)
	);

	dbg_regfile dbg_regfile_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.bus_i(dbg_bus_i.responder),
		.cfg_o(cfg),
		.stat_i(stat)
	);

	dbg_router dbg_router_i (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.cfg_i(cfg),
		.stat_o(stat),
		.cdr_en_ext_pi_ctl_o(cdr_en_ext_pi_ctl_o),
		.cdr_invert_o(cdr_invert_o),
		.cdr_ki_o(cdr_ki_o),
		.cdr_kp_o(cdr_kp_o),
		.cdr_ext_pi_ctl_o(cdr_ext_pi_ctl_o),
		.prbs_checker_mode_o(prbs_checker_mode_o),
		.sram_in_addr_o(sram_in_addr_o),
		.cdr_rst_n_o(cdr_rst_n_o),
		.prbs_rst_n_o(prbs_rst_n_o),
		.sram_rst_n_o(sram_rst_n_o),
		.phase_est_i(phase_est_i),
		.prbs_err_cnt_i(prbs_err_cnt_i),
		.sram_out_data_i(sram_out_data_i)
	);
endmodule

`default_nettype wire

// ==== tests/jtag_driver.svh ====
`ifndef JTAG_DRIVER_SVH
`define JTAG_DRIVER_SVH

// One tck period with the low half first and tdo read before the rise
task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
	tck = 1'b0;
	tms = tms_v;
	tdi = tdi_v;
	repeat (TCK_HALF) @(negedge clk);
	tdo_v = tdo;
	tck = 1'b1;
	repeat (TCK_HALF) @(negedge clk);
endtask

// One tms low leaves Test-Logic-Reset for Run-Test/Idle
task automatic goto_idle();
	logic bit_o;
	tck_cycle(1'b0, 1'b0, bit_o);
endtask

// Starts and ends in Run-Test/Idle
task automatic shift_ir(input logic [jtag_pkg::IR_W-1:0] instr,
		output logic [jtag_pkg::IR_W-1:0] captured);
	logic bit_o;
	tck_cycle(1'b1, 1'b0, bit_o);
	tck_cycle(1'b1, 1'b0, bit_o);
	tck_cycle(1'b0, 1'b0, bit_o);
	tck_cycle(1'b0, 1'b0, bit_o);
	for (int i = 0; i < jtag_pkg::IR_W; i++) begin
		tck_cycle(i == jtag_pkg::IR_W - 1, instr[i], bit_o);
		captured[i] = bit_o;
	end
	tck_cycle(1'b1, 1'b0, bit_o);
	tck_cycle(1'b0, 1'b0, bit_o);
endtask

// Shifts LSB first for up to 32 bits
task automatic shift_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
	logic bit_o;
	dout = '0;
	tck_cycle(1'b1, 1'b0, bit_o);
	tck_cycle(1'b0, 1'b0, bit_o);
	tck_cycle(1'b0, 1'b0, bit_o);
	for (int i = 0; i < len; i++) begin
		tck_cycle(i == len - 1, din[i], bit_o);
		dout[i] = bit_o;
	end
	tck_cycle(1'b1, 1'b0, bit_o);
	tck_cycle(1'b0, 1'b0, bit_o);
endtask

`endif

// ==== tests/tb_jtag_top.sv ====
`default_nettype none

module tb_jtag_top;
	localparam int CLK_PERIOD = 10;
	localparam int TCK_HALF = 8;
	localparam logic [31:0] IDCODE = 32'h2b47_60d3;
	localparam int N_OPS = 19;
	// Longest scan plus the walk through the TAP states
	localparam int SCAN_TCKS = 32 + 6;
	localparam longint WATCHDOG_LIMIT =
		longint'(2 * N_OPS + 12) * longint'(SCAN_TCKS * 2 * TCK_HALF * CLK_PERIOD);

	logic clk;
	logic arst_n;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	logic tdo;
	logic cdr_en;
	logic cdr_invert;
	logic [jtag_pkg::KI_W-1:0] cdr_ki;
	logic [jtag_pkg::KP_W-1:0] cdr_kp;
	logic [jtag_pkg::PI_CTL_W-1:0] cdr_pi;
	logic [jtag_pkg::PRBS_MODE_W-1:0] prbs_mode;
	logic [jtag_pkg::SRAM_ADDR_W-1:0] sram_addr;
	logic cdr_rst_n;
	logic prbs_rst_n;
	logic sram_rst_n;
	logic [jtag_pkg::DATA_W-1:0] phase_est;
	logic [jtag_pkg::DATA_W-1:0] prbs_err;
	logic [jtag_pkg::DATA_W-1:0] sram_data;

	// Entries are {write, addr, data} and a read carries its expected word
	logic [jtag_pkg::ACCESS_DR_W-1:0] ops [N_OPS];
	logic [15:0] cfg_model [4];
	logic [15:0] stat_model [3];
	logic [31:0] rnd;

	jtag_top #(
		.IDCODE(IDCODE),
		.SYNC_STAGES(2)
	) jtag_top_i (
		.clk(clk),
		.arst_n_i(arst_n),
		.tck_i(tck),
		.tms_i(tms),
		.tdi_i(tdi),
		.trst_n_i(trst_n),
		.tdo_o(tdo),
		.cdr_en_ext_pi_ctl_o(cdr_en),
		.cdr_invert_o(cdr_invert),
		.cdr_ki_o(cdr_ki),
		.cdr_kp_o(cdr_kp),
		.cdr_ext_pi_ctl_o(cdr_pi),
		.prbs_checker_mode_o(prbs_mode),
		.sram_in_addr_o(sram_addr),
		.cdr_rst_n_o(cdr_rst_n),
		.prbs_rst_n_o(prbs_rst_n),
		.sram_rst_n_o(sram_rst_n),
		.phase_est_i(phase_est),
		.prbs_err_cnt_i(prbs_err),
		.sram_out_data_i(sram_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	`include "jtag_driver.svh"

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] expected_read(input logic [3:0] addr,
			input logic [15:0] tbl_val);
		case (addr)
			jtag_pkg::ADDR_PHASE_EST: return stat_model[0];
			jtag_pkg::ADDR_PRBS_ERR: return stat_model[1];
			jtag_pkg::ADDR_SRAM_DATA: return stat_model[2];
			default: return tbl_val;
		endcase
	endfunction

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// CDR word fields from the MSB down are en_ext_pi_ctl, invert, ki, kp and ext_pi_ctl
	task automatic check_outputs(input string where);
		expect_equal(32'({cdr_en, cdr_invert, cdr_ki, cdr_kp, cdr_pi}), 32'(cfg_model[0]),
			{where, ": CDR fields"});
		expect_equal(32'(prbs_mode), 32'(cfg_model[1][1:0]), {where, ": PRBS mode"});
		expect_equal(32'(sram_addr), 32'(cfg_model[2][9:0]), {where, ": SRAM address"});
		expect_equal(32'({sram_rst_n, prbs_rst_n, cdr_rst_n}), 32'(cfg_model[3][2:0]),
			{where, ": gated resets"});
	endtask

	initial begin
		ops[0] = {1'b1, 4'd0, 16'ha5c3};
		ops[1] = {1'b1, 4'd1, 16'h0002};
		ops[2] = {1'b1, 4'd2, 16'hf2b7};
		ops[3] = {1'b1, 4'd3, 16'h0005};
		ops[4] = {1'b1, 4'd3, 16'h0007};
		ops[5] = {1'b0, 4'd0, 16'ha5c3};
		ops[6] = {1'b0, 4'd1, 16'h0002};
		ops[7] = {1'b0, 4'd2, 16'hf2b7};
		ops[8] = {1'b0, 4'd3, 16'h0007};
		ops[9] = {1'b0, 4'd8, 16'h0000};
		ops[10] = {1'b0, 4'd9, 16'h0000};
		ops[11] = {1'b0, 4'd10, 16'h0000};
		ops[12] = {1'b1, 4'd9, 16'hdead};
		ops[13] = {1'b0, 4'd9, 16'h0000};
		ops[14] = {1'b0, 4'd5, 16'h0000};
		ops[15] = {1'b1, 4'd6, 16'h1234};
		ops[16] = {1'b0, 4'd6, 16'h0000};
		ops[17] = {1'b1, 4'd0, 16'h5a3c};
		ops[18] = {1'b0, 4'd0, 16'h5a3c};
	end

	initial begin
		logic [31:0] dout;
		logic [jtag_pkg::IR_W-1:0] cap;
		logic [3:0] addr;
		logic [15:0] data;
		clk = 1'b0;
		arst_n = 1'b0;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		phase_est = '0;
		prbs_err = '0;
		sram_data = '0;
		rnd = 32'h41b9_44f8;
		for (int i = 0; i < 4; i++) begin
			cfg_model[i] = '0;
		end
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		rnd = lcg_step(rnd);
		phase_est = rnd[31:16];
		stat_model[0] = rnd[31:16];
		rnd = lcg_step(rnd);
		prbs_err = rnd[31:16];
		stat_model[1] = rnd[31:16];
		rnd = lcg_step(rnd);
		sram_data = rnd[31:16];
		stat_model[2] = rnd[31:16];
		repeat (4) @(negedge clk);

		check_outputs("after reset");
		goto_idle();
		shift_dr(32'h0, 32, dout);
		expect_equal(dout, IDCODE, "IDCODE after reset");

		rnd = lcg_step(rnd);
		shift_ir(jtag_pkg::INSTR_BYPASS, cap);
		expect_equal(32'(cap[1:0]), 32'h1, "IR capture pattern");
		shift_dr(rnd, 32, dout);
		expect_equal(dout, {rnd[30:0], 1'b0}, "BYPASS one-bit delay");
		shift_ir(4'h5, cap);
		shift_dr(~rnd, 32, dout);
		expect_equal(dout, {~rnd[30:0], 1'b0}, "unused opcode acts as BYPASS");

		shift_ir(jtag_pkg::INSTR_REG_ACCESS, cap);
		for (int k = 0; k < N_OPS; k++) begin
			addr = ops[k][19:16];
			data = ops[k][15:0];
			if (ops[k][20]) begin
				shift_dr(32'(ops[k]), jtag_pkg::ACCESS_DR_W, dout);
				if (addr < 4'd4) begin
					cfg_model[addr[1:0]] = data;
				end
				check_outputs($sformatf("write entry %0d", k));
			end else begin
				// First scan issues the read and the second captures rdata
				shift_dr(32'({1'b0, addr, 16'h0}), jtag_pkg::ACCESS_DR_W, dout);
				shift_dr(32'({1'b0, addr, 16'h0}), jtag_pkg::ACCESS_DR_W, dout);
				expect_equal(32'(dout[20:16]), 32'({1'b0, addr}),
					$sformatf("read entry %0d flag and address", k));
				expect_equal(32'(dout[15:0]), 32'(expected_read(addr, data)),
					$sformatf("read entry %0d data", k));
			end
		end

		// TAP reset leaves the configuration alone
		trst_n = 1'b0;
		repeat (2 * TCK_HALF) @(negedge clk);
		trst_n = 1'b1;
		repeat (2 * TCK_HALF) @(negedge clk);
		goto_idle();
		shift_dr(32'h0, 32, dout);
		expect_equal(dout, IDCODE, "IDCODE after trst");
		check_outputs("after trst");

		arst_n = 1'b0;
		@(negedge clk);
		expect_equal(32'({sram_rst_n, prbs_rst_n, cdr_rst_n}), 32'h0, "gated resets in chip reset");
		arst_n = 1'b1;
		for (int i = 0; i < 4; i++) begin
			cfg_model[i] = '0;
		end
		@(negedge clk);
		check_outputs("after second chip reset");

		$display("test passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_LIMIT);
		$display("Timeout: the run did not finish within %0d time units", WATCHDOG_LIMIT);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end
endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
rtl/jtag_pkg.sv
rtl/dbg_bus_if.sv
rtl/tck_sync.sv
rtl/jtag_tap.sv
rtl/dbg_regfile.sv
rtl/dbg_router.sv
rtl/jtag_top.sv
tests/tb_jtag_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_jtag_top
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
